// ==== sources.f ====
+incdir+.
qla_bus_pkg.sv
qla_axis_pkg.sv
qla_encoder.sv
qla_safety_check.sv
qla_axis.sv
qla_board_regs.sv
qla_top.sv
qla_asserts.sv
tb_qla_top.sv

// ==== Makefile ====
# Verilator build and run of the QLA register core testbench

VERILATOR ?= verilator
TOP       ?= tb_qla_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^Result: PASSED" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_qla_top.sv ====
// testbench for qla_top: clock, reset, register map, encoder, enables, safety trip
`timescale 1ns/1ps
`default_nettype none

`include "qla_params.svh"

module tb_qla_top;

    localparam int TEST_CYCLES = 500;                      // longest test, rounded up
    localparam int MAX_CYCLES  = 5 * TEST_CYCLES + 1500;   // five tests plus margin
    localparam logic [15:0] CMD  = `QLA_CUR_MID + 16'd100;
    localparam logic [15:0] LIM  = 16'd200 + `QLA_SAFETY_MARGIN;   // twice cmd plus margin

    logic                        sysclk;
    logic                        arst_n;
    logic [3:0]                  wenid;
    qla_bus_pkg::reg_wr_t        reg_wr;
    logic [15:0]                 reg_raddr;
    logic [31:0]                 reg_rdata;
    qla_axis_pkg::enc_pins_t     enc_pins;
    qla_axis_pkg::cur_array_t    cur_fb;
    logic                        cur_fb_valid;
    qla_axis_pkg::cur_array_t    dac_cmd;
    logic [3:0]                  amp_enable;
    logic                        pwr_enable;
    int                          cycles = 0;
    string                       test_name = "reset";
    logic [15:0]                 dac_exp [4];
    logic [23:0]                 pre_exp [4];
    logic [23:0]                 pre;
    logic [3:0]                  mask;
    logic [1:0]                  phase;                    // quadrature position
    int                          ax;
    int                          n_fwd;
    int                          n_rev;

    qla_top DUT (.*);

    bind qla_top qla_asserts #(.N(`QLA_NUM_AXES)) u_top_asserts (
        .sysclk(sysclk), .arst_n(arst_n), .pwr_enable(pwr_enable),
        .amp_enable(amp_enable), .safety_disable(safety_disable),
        .clear_disable(clear_disable), .dac_cmd(dac_cmd)
    );
    bind qla_safety_check qla_asserts #(.N(1), .HAS_ENABLES(1'b0)) u_safety_asserts (
        .sysclk(sysclk), .arst_n(arst_n), .pwr_enable(1'b0), .amp_enable(1'b0),
        .safety_disable(amp_disable), .clear_disable(clear_disable), .dac_cmd(dac_cmd)
    );

    initial begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;
    end

    function automatic int assert_errors();
        return DUT.u_top_asserts.fail_count
             + DUT.g_axis[0].u_axis.u_safety.u_safety_asserts.fail_count
             + DUT.g_axis[1].u_axis.u_safety.u_safety_asserts.fail_count
             + DUT.g_axis[2].u_axis.u_safety.u_safety_asserts.fail_count
             + DUT.g_axis[3].u_axis.u_safety.u_safety_asserts.fail_count;
    endfunction

    task automatic fail_stop(input string why);
        $display("Result: FAILED");
        $fatal(1, why);
    endtask

    // cycle limit and first assertion failure end the run
    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run exceeded %0d cycles", MAX_CYCLES);
            fail_stop("timeout");
        end
        if (assert_errors() != 0)
            fail_stop("a bound assertion failed");
    end

    // --------------------------------------------------
    // bus helpers
    // --------------------------------------------------
    function automatic logic [15:0] reg_addr(input logic [3:0] space, input int chan,
                                             input logic [3:0] off);
        return {space, 4'h0, chan[3:0], off};   // space | unused | channel | offset
    endfunction

    function automatic logic [31:0] status_word(input logic [3:0] sd, input logic pwr,
                                                input logic [3:0] amp);
        logic [31:0] w;
        w = '0;
        w[31:28] = ~wenid;
        w[27:24] = sd;
        w[19]    = pwr;
        w[3:0]   = amp;
        return w;
    endfunction

    // masked enable write: power mask/value at 19/18, amp mask at 11..8
    function automatic logic [31:0] enable_word(input logic pwr_wen, input logic pwr,
                                                input logic [3:0] amask, input logic [3:0] aval);
        logic [31:0] w;
        w = '0;
        w[19]   = pwr_wen;
        w[18]   = pwr;
        w[11:8] = amask;
        w[3:0]  = aval;
        return w;
    endfunction

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        @(posedge sysclk);
        reg_wr <= '{wen: 1'b1, waddr: addr, wdata: data};
        @(posedge sysclk);                      // write lands here
        reg_wr.wen <= 1'b0;
    endtask

    task automatic check_val(input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail %s: expected %h actual %h", test_name, exp, act);
            fail_stop("readback mismatch");
        end
    endtask

    task automatic read_check(input logic [15:0] addr, input logic [31:0] exp);
        @(posedge sysclk);
        reg_raddr <= addr;
        @(negedge sysclk);                      // rdata settled mid-cycle
        check_val(exp, reg_rdata);
    endtask

    // gray order 00 10 11 01 with a leading, three cycles to reach the count
    task automatic drive_enc(input int axis, input logic [1:0] ph);
        @(posedge sysclk);
        enc_pins.a[axis] <= ph[1] ^ ph[0];
        enc_pins.b[axis] <= ph[1];
        repeat (4) @(posedge sysclk);
    endtask

    task automatic fb_sample(input logic [15:0] value);
        @(posedge sysclk);
        cur_fb[0]    <= value;
        cur_fb_valid <= 1'b1;
        @(posedge sysclk);                      // safety evaluates here
        cur_fb_valid <= 1'b0;
    endtask

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    initial begin
        void'($urandom(32'hb233));
        arst_n       = 1'b1;
        wenid        = 4'($urandom);
        reg_wr       = '0;
        reg_raddr    = '0;
        enc_pins     = '0;
        cur_fb       = {4{`QLA_CUR_MID}};
        cur_fb_valid = 1'b0;
        phase        = 2'd0;
        @(posedge sysclk);
        arst_n <= 1'b0;
        repeat (10) @(posedge sysclk);
        arst_n <= 1'b1;

        // 1. reset state
        @(negedge sysclk);
        check_val(32'h0, {27'h0, pwr_enable, amp_enable});
        for (int i = 0; i < 4; i++)
            check_val({16'h0, `QLA_CUR_MID}, {16'h0, dac_cmd[i]});
        read_check(reg_addr(4'h0, 0, qla_bus_pkg::OFF_STATUS), status_word(4'h0, 1'b0, 4'h0));
        for (int i = 0; i < 4; i++)
            read_check(reg_addr(4'h0, i + 1, qla_bus_pkg::OFF_ENC_DATA), 32'h0);

        // 2. register map
        test_name = "register map";
        for (int i = 0; i < 4; i++) begin
            dac_exp[i] = 16'($urandom);
            pre_exp[i] = 24'($urandom);
            // random upper bits must not reach the registers
            write_reg(reg_addr(4'h0, i + 1, qla_bus_pkg::OFF_DAC_CTRL),
                      {16'($urandom), dac_exp[i]});
            write_reg(reg_addr(4'h0, i + 1, qla_bus_pkg::OFF_ENC_LOAD),
                      {8'($urandom), pre_exp[i]});
        end
        for (int i = 0; i < 4; i++) begin
            read_check(reg_addr(4'h0, i + 1, qla_bus_pkg::OFF_DAC_CTRL), {16'h0, dac_exp[i]});
            check_val({16'h0, dac_exp[i]}, {16'h0, dac_cmd[i]});
            read_check(reg_addr(4'h0, i + 1, qla_bus_pkg::OFF_ENC_LOAD), {8'h0, pre_exp[i]});
        end
        read_check(reg_addr(4'h0, 1, 4'h2), 32'h0);              // unused offset
        read_check(reg_addr(4'h0, 5, qla_bus_pkg::OFF_DAC_CTRL), 32'h0);
        read_check(reg_addr(4'h3, 1, qla_bus_pkg::OFF_DAC_CTRL), 32'h0);

        // 3. encoder
        test_name = "encoder";
        ax    = $urandom % 4;
        pre   = 24'($urandom);
        n_fwd = 21 + $urandom % 20;                               // net move never zero
        n_rev = 1 + $urandom % 20;
        write_reg(reg_addr(4'h0, ax + 1, qla_bus_pkg::OFF_ENC_LOAD), {8'h0, pre});
        write_reg(reg_addr(4'h0, ax + 1, qla_bus_pkg::OFF_ENC_DATA), 32'h0);
        read_check(reg_addr(4'h0, ax + 1, qla_bus_pkg::OFF_ENC_DATA), {8'h0, pre});
        repeat (n_fwd) begin
            phase = phase + 2'd1;
            drive_enc(ax, phase);
        end
        repeat (n_rev) begin
            phase = phase - 2'd1;
            drive_enc(ax, phase);
        end
        pre = pre + 24'(n_fwd) - 24'(n_rev);                     // wraps mod 2^24
        read_check(reg_addr(4'h0, ax + 1, qla_bus_pkg::OFF_ENC_DATA), {8'h0, pre});
        phase = phase + 2'd2;                                     // both pins flip
        drive_enc(ax, phase);
        read_check(reg_addr(4'h0, ax + 1, qla_bus_pkg::OFF_ENC_DATA), {8'h0, pre});

        // 4. power and amp enables
        test_name = "enables";
        mask = 4'($urandom);
        write_reg(reg_addr(4'h0, 0, qla_bus_pkg::OFF_STATUS), enable_word(1'b1, 1'b1, 4'hf, mask));
        @(negedge sysclk);
        check_val({28'h0, mask}, {28'h0, amp_enable});
        read_check(reg_addr(4'h0, 0, qla_bus_pkg::OFF_STATUS), status_word(4'h0, 1'b1, mask));
        write_reg(reg_addr(4'h0, 0, qla_bus_pkg::OFF_STATUS), enable_word(1'b1, 1'b0, 4'h0, 4'h0));
        @(negedge sysclk);
        check_val(32'h0, {27'h0, pwr_enable, amp_enable});
        read_check(reg_addr(4'h0, 0, qla_bus_pkg::OFF_STATUS), status_word(4'h0, 1'b0, 4'h0));

        // 5. overcurrent trip on axis 0
        test_name = "safety";
        write_reg(reg_addr(4'h0, 0, qla_bus_pkg::OFF_STATUS), enable_word(1'b1, 1'b1, 4'hf, 4'hf));
        write_reg(reg_addr(4'h0, 1, qla_bus_pkg::OFF_DAC_CTRL), {16'h0, CMD});
        repeat (`QLA_SAFETY_COUNT + 2) fb_sample(`QLA_CUR_MID + LIM - 16'd1);
        read_check(reg_addr(4'h0, 0, qla_bus_pkg::OFF_STATUS), status_word(4'h0, 1'b1, 4'hf));
        repeat (`QLA_SAFETY_COUNT - 1) fb_sample(`QLA_CUR_MID + LIM + 16'd1);
        fb_sample(`QLA_CUR_MID);                                  // good one resets the run
        read_check(reg_addr(4'h0, 0, qla_bus_pkg::OFF_STATUS), status_word(4'h0, 1'b1, 4'hf));
        repeat (`QLA_SAFETY_COUNT - 1) fb_sample(`QLA_CUR_MID + LIM + 16'd1);
        read_check(reg_addr(4'h0, 0, qla_bus_pkg::OFF_STATUS), status_word(4'h0, 1'b1, 4'hf));
        fb_sample(`QLA_CUR_MID + LIM + 16'd1);                    // last bad one trips
        @(negedge sysclk);
        check_val(32'he, {28'h0, amp_enable});
        read_check(reg_addr(4'h0, 0, qla_bus_pkg::OFF_STATUS), status_word(4'h1, 1'b1, 4'he));
        read_check(reg_addr(4'h0, 1, qla_bus_pkg::OFF_ADC_DATA),
                   {16'h0, `QLA_CUR_MID + LIM + 16'd1});
        write_reg(reg_addr(4'h0, 0, qla_bus_pkg::OFF_STATUS), enable_word(1'b0, 1'b0, 4'h1, 4'h1));
        read_check(reg_addr(4'h0, 0, qla_bus_pkg::OFF_STATUS), status_word(4'h0, 1'b1, 4'hf));
        @(posedge sysclk);
        cur_fb[0] <= `QLA_CUR_MID;
        repeat (2) @(posedge sysclk);

        if (assert_errors() == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            fail_stop("a bound assertion failed");
        end
    end

endmodule

`default_nettype wire

// ==== qla_asserts.sv ====
// bound checks: idle outputs in reset, enable gating, safety latch hold
`timescale 1ns/1ps
`default_nettype none

`include "qla_params.svh"

module qla_asserts #(
    parameter int N           = `QLA_NUM_AXES,        // axes seen by this instance
    parameter bit HAS_ENABLES = 1'b1                  // amp and power enables live here
) (
    input  logic                             sysclk,
    input  logic                             arst_n,
    input  logic                             pwr_enable,
    input  logic [N-1:0]                     amp_enable,
    input  logic [N-1:0]                     safety_disable,
    input  logic [N-1:0]                     clear_disable,
    input  logic [N-1:0][`QLA_CUR_WIDTH-1:0] dac_cmd
);

    int fail_count = 0;                               // read by the testbench

    // --------------------------------------------------
    // reset state
    // --------------------------------------------------
    reset_idle: assert property (@(posedge sysclk)
        !arst_n |-> (amp_enable == '0 && !pwr_enable && safety_disable == '0
                     && dac_cmd == {N{`QLA_CUR_MID}}))
        else begin
            fail_count++;
            $error("outputs active or dac not at mid-scale during reset");
        end

    if (HAS_ENABLES) begin : g_enables
        // amps need power
        amp_needs_pwr: assert property (@(posedge sysclk) disable iff (!arst_n)
            |amp_enable |-> pwr_enable)
            else begin
                fail_count++;
                $error("amp enabled while power is off");
            end

        amp_not_tripped: assert property (@(posedge sysclk) disable iff (!arst_n)
            (amp_enable & safety_disable) == '0)
            else begin
                fail_count++;
                $error("amp enabled on a tripped axis");
            end
    end

    // --------------------------------------------------
    // tripped latch only drops on clear
    // --------------------------------------------------
    for (genvar i = 0; i < N; i++) begin : g_latch
        latch_hold: assert property (@(posedge sysclk) disable iff (!arst_n)
            safety_disable[i] && !clear_disable[i] |=> safety_disable[i])
            else begin
                fail_count++;
                $error("safety disable %0d dropped without a clear", i);
            end
    end

endmodule

`default_nettype wire

// ==== qla_top.sv ====
// top level: address decode, board registers, four axes, read data mux
`timescale 1ns/1ps
`default_nettype none

`include "qla_params.svh"

module qla_top (
    input  logic                       sysclk,
    input  logic                       arst_n,
    input  logic [3:0]                 wenid,       // rotary switch, active low
    input  qla_bus_pkg::reg_wr_t       reg_wr,
    input  logic [`QLA_ADDR_WIDTH-1:0] reg_raddr,
    output logic [`QLA_DATA_WIDTH-1:0] reg_rdata,
    input  qla_axis_pkg::enc_pins_t    enc_pins,
    input  qla_axis_pkg::cur_array_t   cur_fb,
    input  logic                       cur_fb_valid, // shared by all axes
    output qla_axis_pkg::cur_array_t   dac_cmd,
    output logic [`QLA_NUM_AXES-1:0]   amp_enable,
    output logic                       pwr_enable
);

    logic                       wr_main;        // write into main space
    logic [3:0]                 wchan;
    logic [3:0]                 rchan;
    logic [`QLA_OFF_MSB:0]      raddr_off;
    logic [`QLA_DATA_WIDTH-1:0] board_rdata;
    logic [`QLA_DATA_WIDTH-1:0] axis_rdata [`QLA_NUM_AXES];
    logic [`QLA_NUM_AXES-1:0]   safety_disable;
    logic [`QLA_NUM_AXES-1:0]   clear_disable;

    // --------------------------------------------------
    // address decode
    // --------------------------------------------------
    assign wr_main   = reg_wr.wen && (reg_wr.waddr[`QLA_SPACE_MSB:`QLA_SPACE_LSB]
                                      == qla_bus_pkg::ADDR_MAIN);
    assign wchan     = reg_wr.waddr[`QLA_CHAN_MSB:`QLA_CHAN_LSB];
    assign rchan     = reg_raddr[`QLA_CHAN_MSB:`QLA_CHAN_LSB];
    assign raddr_off = reg_raddr[`QLA_OFF_MSB:0];

    qla_board_regs u_board (
        .sysclk         (sysclk),
        .arst_n         (arst_n),
        .wenid          (wenid),
        .wr_sel         (wr_main && (wchan == `QLA_CHAN_BOARD)),
        .reg_wr         (reg_wr),
        .raddr_off      (raddr_off),
        .rdata          (board_rdata),
        .safety_disable (safety_disable),
        .clear_disable  (clear_disable),
        .amp_enable     (amp_enable),
        .pwr_enable     (pwr_enable)
    );

    // axis i sits at channel i+1
    for (genvar i = 0; i < `QLA_NUM_AXES; i++) begin : g_axis
        qla_axis u_axis (
            .sysclk         (sysclk),
            .arst_n         (arst_n),
            .wr_sel         (wr_main && (wchan == 4'(i + 1))),
            .reg_wr         (reg_wr),
            .raddr_off      (raddr_off),
            .rdata          (axis_rdata[i]),
            .enc_a          (enc_pins.a[i]),
            .enc_b          (enc_pins.b[i]),
            .cur_fb         (cur_fb[i]),
            .cur_fb_valid   (cur_fb_valid),
            .clear_disable  (clear_disable[i]),
            .dac_cmd        (dac_cmd[i]),
            .safety_disable (safety_disable[i])
        );
    end

    // read mux, combinational; other spaces and channels read zero
    always_comb begin
        reg_rdata = '0;
        if (reg_raddr[`QLA_SPACE_MSB:`QLA_SPACE_LSB] == qla_bus_pkg::ADDR_MAIN) begin
            if (rchan == `QLA_CHAN_BOARD)
                reg_rdata = board_rdata;
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                if (rchan == 4'(i + 1))
                    reg_rdata = axis_rdata[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== qla_board_regs.sv ====
// channel 0 status register: board id, power and amp enables, safety disable mirror
`timescale 1ns/1ps
`default_nettype none

`include "qla_params.svh"

module qla_board_regs (
    input  logic                       sysclk,
    input  logic                       arst_n,
    input  logic [3:0]                 wenid,          // rotary switch, active low
    input  logic                       wr_sel,         // write to channel 0
    input  qla_bus_pkg::reg_wr_t       reg_wr,
    input  logic [`QLA_OFF_MSB:0]      raddr_off,
    output logic [`QLA_DATA_WIDTH-1:0] rdata,
    input  logic [`QLA_NUM_AXES-1:0]   safety_disable,
    output logic [`QLA_NUM_AXES-1:0]   clear_disable,
    output logic [`QLA_NUM_AXES-1:0]   amp_enable,
    output logic                       pwr_enable
);

    logic                     status_wr;
    logic                     pwr_on_wr;      // power written to 1
    logic [`QLA_NUM_AXES-1:0] amp_reg;        // requested amp enables
    logic [`QLA_NUM_AXES-1:0] amp_mask;       // which amps this write touches

    assign status_wr = wr_sel &&
                       (reg_wr.waddr[`QLA_OFF_MSB:0] == qla_bus_pkg::OFF_STATUS);
    assign amp_mask  = reg_wr.wdata[`QLA_ST_AMP_WEN_LSB +: `QLA_NUM_AXES];
    assign pwr_on_wr = status_wr && reg_wr.wdata[`QLA_ST_PWR_WEN]
                                 && reg_wr.wdata[`QLA_ST_PWR];

    // --------------------------------------------------
    // enable registers, masked write
    // --------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            pwr_enable <= 1'b0;
            amp_reg    <= '0;
        end else if (status_wr) begin
            if (reg_wr.wdata[`QLA_ST_PWR_WEN])
                pwr_enable <= reg_wr.wdata[`QLA_ST_PWR];
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                if (amp_mask[i])
                    amp_reg[i] <= reg_wr.wdata[i];
            end
        end
    end

    // enabling power or an amp re-arms its safety latch, same edge as the write
    always_comb begin
        for (int i = 0; i < `QLA_NUM_AXES; i++)
            clear_disable[i] = pwr_on_wr ||
                               (status_wr && amp_mask[i] && reg_wr.wdata[i]);
    end

    // a tripped axis stays off even if requested
    assign amp_enable = {`QLA_NUM_AXES{pwr_enable}} & amp_reg & ~safety_disable;

    // --------------------------------------------------
    // status read
    // --------------------------------------------------
    always_comb begin
        rdata = '0;
        if (raddr_off == qla_bus_pkg::OFF_STATUS) begin
            rdata[31:28] = ~wenid;                  // board id
            rdata[27:24] = safety_disable;
            rdata[19]    = pwr_enable;
            rdata[3:0]   = amp_enable;
        end
    end

endmodule

`default_nettype wire

// ==== qla_axis.sv ====
// one motor axis: dac command and adc feedback registers, encoder, safety check, read mux
`timescale 1ns/1ps
`default_nettype none

`include "qla_params.svh"

module qla_axis (
    input  logic                       sysclk,
    input  logic                       arst_n,
    input  logic                       wr_sel,        // write aimed at this axis
    input  qla_bus_pkg::reg_wr_t       reg_wr,
    input  logic [`QLA_OFF_MSB:0]      raddr_off,
    output logic [`QLA_DATA_WIDTH-1:0] rdata,
    input  logic                       enc_a,
    input  logic                       enc_b,
    input  logic [`QLA_CUR_WIDTH-1:0]  cur_fb,
    input  logic                       cur_fb_valid,
    input  logic                       clear_disable,
    output logic [`QLA_CUR_WIDTH-1:0]  dac_cmd,
    output logic                       safety_disable
);

    logic [`QLA_OFF_MSB:0]     woff;
    logic                      dac_wen;
    logic                      preload_wen;
    logic                      load_wen;
    logic [`QLA_CUR_WIDTH-1:0] fb_reg;         // last sampled feedback
    logic [`QLA_ENC_WIDTH-1:0] enc_preload;
    logic [`QLA_ENC_WIDTH-1:0] enc_count;

    // --------------------------------------------------
    // write decode
    // --------------------------------------------------
    assign woff        = reg_wr.waddr[`QLA_OFF_MSB:0];
    assign dac_wen     = wr_sel && (woff == qla_bus_pkg::OFF_DAC_CTRL);
    assign preload_wen = wr_sel && (woff == qla_bus_pkg::OFF_ENC_LOAD);
    assign load_wen    = wr_sel && (woff == qla_bus_pkg::OFF_ENC_DATA);

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n)
            dac_cmd <= `QLA_CUR_MID;       // zero current out of reset
        else if (dac_wen)
            dac_cmd <= reg_wr.wdata[`QLA_CUR_WIDTH-1:0];
    end

    always_ff @(posedge sysclk) begin
        if (cur_fb_valid)
            fb_reg <= cur_fb;
    end

    qla_encoder u_enc (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .enc_a       (enc_a),
        .enc_b       (enc_b),
        .preload_wen (preload_wen),
        .load_wen    (load_wen),
        .wdata       (reg_wr.wdata[`QLA_ENC_WIDTH-1:0]),
        .preload     (enc_preload),
        .count       (enc_count)
    );

    // checks the live word at the valid edge, not fb_reg
    qla_safety_check u_safety (
        .sysclk        (sysclk),
        .arst_n        (arst_n),
        .cur_fb        (cur_fb),
        .dac_cmd       (dac_cmd),
        .sample        (cur_fb_valid),
        .clear_disable (clear_disable),
        .amp_disable   (safety_disable)
    );

    // read mux, everything zero-extended
    always_comb begin
        rdata = '0;
        case (raddr_off)
            qla_bus_pkg::OFF_ADC_DATA: rdata[`QLA_CUR_WIDTH-1:0] = fb_reg;
            qla_bus_pkg::OFF_DAC_CTRL: rdata[`QLA_CUR_WIDTH-1:0] = dac_cmd;
            qla_bus_pkg::OFF_ENC_LOAD: rdata[`QLA_ENC_WIDTH-1:0] = enc_preload;
            qla_bus_pkg::OFF_ENC_DATA: rdata[`QLA_ENC_WIDTH-1:0] = enc_count;
            default:                   rdata = '0;  // unused offsets
        endcase
    end

endmodule

`default_nettype wire

// ==== qla_safety_check.sv ====
// overcurrent compare against twice the command, bad sample counter, latched amp disable
`timescale 1ns/1ps
`default_nettype none

`include "qla_params.svh"

module qla_safety_check (
    input  logic                      sysclk,
    input  logic                      arst_n,
    input  logic [`QLA_CUR_WIDTH-1:0] cur_fb,
    input  logic [`QLA_CUR_WIDTH-1:0] dac_cmd,
    input  logic                      sample,           // feedback valid strobe
    input  logic                      clear_disable,
    output logic                      amp_disable
);

    localparam int CNT_W = $clog2(`QLA_SAFETY_COUNT + 1);

    qla_axis_pkg::safety_state_e  state;
    logic [CNT_W-1:0]             bad_cnt;      // consecutive bad samples
    logic [`QLA_CUR_WIDTH-1:0]    fb_mag;       // |fb - mid|
    logic [`QLA_CUR_WIDTH-1:0]    cmd_mag;      // |cmd - mid|
    logic [`QLA_CUR_WIDTH+1:0]    limit;        // 2*cmd + margin, no overflow
    logic                         over;

    // --------------------------------------------------
    // distances from mid-scale
    // --------------------------------------------------
    assign fb_mag  = (cur_fb >= `QLA_CUR_MID) ? cur_fb - `QLA_CUR_MID
                                              : `QLA_CUR_MID - cur_fb;
    assign cmd_mag = (dac_cmd >= `QLA_CUR_MID) ? dac_cmd - `QLA_CUR_MID
                                               : `QLA_CUR_MID - dac_cmd;
    assign limit   = {1'b0, cmd_mag, 1'b0} + (`QLA_CUR_WIDTH+2)'(`QLA_SAFETY_MARGIN);
    assign over    = {2'b00, fb_mag} > limit;

    // ok -> counting -> tripped, a good sample drops back to ok
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= qla_axis_pkg::SAFE_OK;
            bad_cnt <= '0;
        end else if (clear_disable) begin
            state   <= qla_axis_pkg::SAFE_OK;          // only way out of tripped
            bad_cnt <= '0;
        end else if (sample && state != qla_axis_pkg::SAFE_TRIPPED) begin
            if (!over) begin
                state   <= qla_axis_pkg::SAFE_OK;
                bad_cnt <= '0;
            end else if (bad_cnt == CNT_W'(`QLA_SAFETY_COUNT - 1)) begin
                state   <= qla_axis_pkg::SAFE_TRIPPED; // this is the last bad one
            end else begin
                state   <= qla_axis_pkg::SAFE_COUNTING;
                bad_cnt <= bad_cnt + CNT_W'(1);
            end
        end
    end

    assign amp_disable = (state == qla_axis_pkg::SAFE_TRIPPED);

endmodule

`default_nettype wire

// ==== qla_encoder.sv ====
// quadrature decoder with pin synchronizer, up/down counter and preload register
`timescale 1ns/1ps
`default_nettype none

`include "qla_params.svh"

module qla_encoder (
    input  logic                      sysclk,
    input  logic                      arst_n,
    input  logic                      enc_a,
    input  logic                      enc_b,
    input  logic                      preload_wen,  // store wdata as preload
    input  logic                      load_wen,     // copy preload into count
    input  logic [`QLA_ENC_WIDTH-1:0] wdata,
    output logic [`QLA_ENC_WIDTH-1:0] preload,
    output logic [`QLA_ENC_WIDTH-1:0] count
);

    logic [`QLA_SYNC_STAGES-1:0] a_sync;    // [0] sees the pin first
    logic [`QLA_SYNC_STAGES-1:0] b_sync;
    logic                        a_now;
    logic                        b_now;
    logic                        a_prev;    // last synchronized value
    logic                        b_prev;
    logic                        step;
    logic                        up;

    // --------------------------------------------------
    // pin synchronizers
    // --------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            a_sync <= '0;
            b_sync <= '0;
            a_prev <= 1'b0;
            b_prev <= 1'b0;
        end else begin
            a_sync <= {a_sync[`QLA_SYNC_STAGES-2:0], enc_a};
            b_sync <= {b_sync[`QLA_SYNC_STAGES-2:0], enc_b};
            a_prev <= a_now;
            b_prev <= b_now;
        end
    end

    assign a_now = a_sync[`QLA_SYNC_STAGES-1];
    assign b_now = b_sync[`QLA_SYNC_STAGES-1];

    // exactly one pin moved, both at once is an illegal jump and is dropped
    assign step = (a_now ^ a_prev) ^ (b_now ^ b_prev);
    // gray order 00 10 11 01 when a leads
    assign up   = a_now ^ b_prev;

    // --------------------------------------------------
    // preload and count
    // --------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            preload <= '0;
            count   <= '0;
        end else begin
            if (preload_wen)
                preload <= wdata;
            if (load_wen)
                count <= preload;                   // load wins over a step
            else if (step)
                count <= up ? count + `QLA_ENC_WIDTH'(1)
                            : count - `QLA_ENC_WIDTH'(1);   // wraps mod 2^24
        end
    end

endmodule

`default_nettype wire

// ==== qla_axis_pkg.sv ====
// encoder pin struct, current word array type and safety FSM state enum
`default_nettype none

`include "qla_params.svh"

package qla_axis_pkg;

    // encoder connector pins, one bit per axis
    typedef struct packed {
        logic [`QLA_NUM_AXES-1:0] a;
        logic [`QLA_NUM_AXES-1:0] b;
    } enc_pins_t;

    // one current word per axis, axis 0 in the low word
    typedef logic [`QLA_NUM_AXES-1:0][`QLA_CUR_WIDTH-1:0] cur_array_t;

    // --------------------------------------------------
    // overcurrent check states
    // --------------------------------------------------
    typedef enum logic [1:0] {
        SAFE_OK,            // no recent overcurrent
        SAFE_COUNTING,      // bad samples seen, not yet enough
        SAFE_TRIPPED        // amp held off until cleared
    } safety_state_e;

endpackage

`default_nettype wire

// ==== qla_bus_pkg.sv ====
// register bus write struct, address space and register offset enums
`default_nettype none

`include "qla_params.svh"

package qla_bus_pkg;

    // write side of the register bus, one cycle per write
    typedef struct packed {
        logic                       wen;    // write strobe
        logic [`QLA_ADDR_WIDTH-1:0] waddr;
        logic [`QLA_DATA_WIDTH-1:0] wdata;
    } reg_wr_t;

    // address bits 15..12
    // only main is mapped, everything else reads zero
    typedef enum logic [`QLA_SPACE_MSB-`QLA_SPACE_LSB:0] {
        ADDR_MAIN = 4'h0
    } addr_space_e;

    // --------------------------------------------------
    // offsets within a channel, address bits 3..0
    // --------------------------------------------------
    typedef enum logic [`QLA_OFF_MSB:0] {
        OFF_ADC_DATA = 4'h0,    // axes: sampled current feedback
        OFF_DAC_CTRL = 4'h1,    // current command
        OFF_ENC_LOAD = 4'h4,    // encoder preload
        OFF_ENC_DATA = 4'h5     // encoder count, write loads preload
    } reg_offset_e;

    // channel 0 status shares offset 0 with adc data
    parameter reg_offset_e OFF_STATUS = OFF_ADC_DATA;

endpackage

`default_nettype wire

// ==== qla_params.svh ====
// sizes, address fields, status word bit positions and safety limits
`ifndef QLA_PARAMS_SVH
`define QLA_PARAMS_SVH

// --------------------------------------------------
// sizes
// --------------------------------------------------
`define QLA_NUM_AXES        4
`define QLA_ADDR_WIDTH      16
`define QLA_DATA_WIDTH      32
`define QLA_ENC_WIDTH       24          // quadrature count, wraps
`define QLA_CUR_WIDTH       16          // dac / adc word
`define QLA_SYNC_STAGES     2           // encoder pin synchronizer

// address fields: space | unused | channel | offset
`define QLA_SPACE_MSB       15
`define QLA_SPACE_LSB       12
`define QLA_CHAN_MSB        7
`define QLA_CHAN_LSB        4
`define QLA_OFF_MSB         3
`define QLA_CHAN_BOARD      4'd0        // channel 0 is board status

// status word write fields
`define QLA_ST_PWR_WEN      19          // mask bit for power enable
`define QLA_ST_PWR          18          // power enable value
`define QLA_ST_AMP_WEN_LSB  8           // amp i mask at 8+i, value at i

// --------------------------------------------------
// safety check
// --------------------------------------------------
`define QLA_CUR_MID         16'h8000    // zero current, offset binary
`define QLA_SAFETY_MARGIN   16'h0100
`define QLA_SAFETY_COUNT    8           // bad samples in a row to trip

`endif
